// ==== Bender.yml ====
package:
  name: hub_core

sources:
  - hw/hub_pkg.sv
  - hw/hub_wb_if.sv
  - hw/serial_bus_tx.sv
  - hw/serial_bus_rx.sv
  - hw/bus_channel.sv
  - hw/uplink_arbiter.sv
  - hw/hub_core.sv
  - target: test
    files:
      - tb/tb_hub_core.sv

// ==== all.f ====
hw/hub_pkg.sv
hw/hub_wb_if.sv
hw/serial_bus_tx.sv
hw/serial_bus_rx.sv
hw/bus_channel.sv
hw/uplink_arbiter.sv
hw/hub_core.sv
tb/tb_hub_core.sv

// ==== hw/bus_channel.sv ====
`default_nettype none
`timescale 1ns/1ns

module bus_channel (
  input  logic     clk,
  input  logic     rst,
  hub_wb_if.slave  dl,
  hub_wb_if.master rx_frame,
  output logic     tx,
  input  logic     rx
);

  logic                  frame_valid;
  hub_pkg::bus_payload_t frame;
  hub_pkg::bus_payload_t held;
  logic                  full;

  serial_bus_tx i_tx (
    .clk (clk),
    .rst (rst),
    .dl  (dl),
    .tx  (tx)
  );

  serial_bus_rx i_rx (
    .clk         (clk),
    .rst         (rst),
    .rx          (rx),
    .frame_valid (frame_valid),
    .frame       (frame)
  );

  // Newest frame wins, the bus is never held off
  always_ff @(posedge clk)
  begin
    if (frame_valid)
    begin
      held <= frame;
    end
  end

  always_ff @(posedge clk)
  begin
    if (!rst)
    begin
      full <= 1'b0;
    end
    else if (frame_valid)
    begin
      full <= 1'b1;
    end
    else if (rx_frame.ack)
    begin
      full <= 1'b0;
    end
  end

  // Held frame is offered upstream until acked
  assign rx_frame.cyc = full;
  assign rx_frame.stb = full;
  assign rx_frame.dat = held;

endmodule

`default_nettype wire

// ==== hw/hub_core.sv ====
`default_nettype none
`timescale 1ns/1ns

module hub_core (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        down_cyc,
  input  logic                        down_stb,
  input  hub_pkg::hub_frame_t         down_dat,
  output logic                        down_ack,
  output logic                        up_cyc,
  output logic                        up_stb,
  output hub_pkg::hub_frame_t         up_dat,
  input  logic                        up_ack,
  output logic [hub_pkg::n_buses-1:0] tx,
  input  logic [hub_pkg::n_buses-1:0] rx
);

  logic [hub_pkg::n_buses-1:0] dl_ack;
  logic                        bad_id;
  logic                        bad_ack;

  hub_wb_if #(.payload_t(hub_pkg::bus_payload_t)) dl_if [hub_pkg::n_buses] ();
  hub_wb_if #(.payload_t(hub_pkg::bus_payload_t)) rx_if [hub_pkg::n_buses] ();

  assign bad_id = (down_dat.bus_id >= hub_pkg::n_buses);

  for (genvar i = 0; i < hub_pkg::n_buses; i++)
  begin : g_bus
    // Downlink decode on bus_id
    assign dl_if[i].cyc = down_cyc && (down_dat.bus_id == i);
    assign dl_if[i].stb = down_stb && (down_dat.bus_id == i);
    assign dl_if[i].dat = down_dat.payload;
    assign dl_ack[i]    = dl_if[i].ack;

    bus_channel i_channel (
      .clk      (clk),
      .rst      (rst),
      .dl       (dl_if[i]),
      .rx_frame (rx_if[i]),
      .tx       (tx[i]),
      .rx       (rx[i])
    );
  end

  // Unknown bus ids are acked here and dropped
  always_ff @(posedge clk)
  begin
    if (!rst)
    begin
      bad_ack <= 1'b0;
    end
    else
    begin
      bad_ack <= down_cyc && down_stb && bad_id && !bad_ack;
    end
  end

  assign down_ack = (|dl_ack) || bad_ack;

  uplink_arbiter i_arbiter (
    .clk    (clk),
    .rst    (rst),
    .req    (rx_if),
    .up_cyc (up_cyc),
    .up_stb (up_stb),
    .up_dat (up_dat),
    .up_ack (up_ack)
  );

endmodule

`default_nettype wire

// ==== hw/hub_pkg.sv ====
`default_nettype none

package hub_pkg;

  // Bus topology
  localparam int n_buses = 8;
  localparam int chan_w = $clog2(n_buses);
  localparam int bus_id_w = 5;

  // Message fields
  localparam int cob_id_w = 11;
  localparam int dlc_w = 4;
  localparam int data_w = 56;

  // One message as it travels on a bus line
  typedef struct packed {
    logic [cob_id_w-1:0] cob_id;
    logic [dlc_w-1:0]    dlc;
    logic [data_w-1:0]   data;
  } bus_payload_t;

  // Message tagged with its bus, as seen on the host link
  typedef struct packed {
    logic [bus_id_w-1:0] bus_id;
    bus_payload_t        payload;
  } hub_frame_t;

  localparam int payload_w = $bits(bus_payload_t);

  // Line timing, start bit plus payload plus stop bit
  localparam int bit_cycles = 4;
  localparam int frame_bits = payload_w + 2;
  localparam int cyc_cnt_w = $clog2(bit_cycles);
  localparam int bit_cnt_w = $clog2(frame_bits);

endpackage

`default_nettype wire

// ==== hw/hub_wb_if.sv ====
`default_nettype none
`timescale 1ns/1ns

// Write-only Wishbone classic, data always flows master to slave
interface hub_wb_if #(
  parameter type payload_t = logic
);

  logic     cyc;
  logic     stb;
  payload_t dat;
  logic     ack;

  modport master (
    output cyc,
    output stb,
    output dat,
    input  ack
  );

  modport slave (
    input  cyc,
    input  stb,
    input  dat,
    output ack
  );

endinterface

`default_nettype wire

// ==== hw/serial_bus_rx.sv ====
`default_nettype none
`timescale 1ns/1ns

module serial_bus_rx (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  rx,
  output logic                  frame_valid,
  output hub_pkg::bus_payload_t frame
);

  logic                           rx_meta;
  logic                           rx_sync;
  logic                           rx_prev;
  logic                           busy;
  logic                           sample;
  logic [hub_pkg::cyc_cnt_w-1:0]  cyc_cnt;
  logic [hub_pkg::bit_cnt_w-1:0]  bit_cnt;
  logic [hub_pkg::payload_w-1:0]  shreg;

  // Counter runs from the detected edge, so this lands mid-bit
  assign sample = busy && (cyc_cnt == (hub_pkg::bit_cycles / 2 - 1));
  assign frame  = hub_pkg::bus_payload_t'(shreg);

  // Synchronizer, idles high like the line
  always_ff @(posedge clk)
  begin
    if (!rst)
    begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end
    else
    begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  // Payload bits arrive LSB first, start and stop bits are not stored
  always_ff @(posedge clk)
  begin
    if (sample && (bit_cnt != 0) && (bit_cnt != (hub_pkg::frame_bits - 1)))
    begin
      shreg <= {rx_sync, shreg[hub_pkg::payload_w-1:1]};
    end
  end

  always_ff @(posedge clk)
  begin
    if (!rst)
    begin
      busy        <= 1'b0;
      cyc_cnt     <= '0;
      bit_cnt     <= '0;
      frame_valid <= 1'b0;
    end
    else
    begin
      frame_valid <= 1'b0;
      if (!busy)
      begin
        if (rx_prev && !rx_sync)
        begin
          busy    <= 1'b1;
          cyc_cnt <= '0;
          bit_cnt <= '0;
        end
      end
      else
      begin
        cyc_cnt <= (cyc_cnt == (hub_pkg::bit_cycles - 1)) ? '0 : cyc_cnt + 1'b1;
        if (sample)
        begin
          bit_cnt <= bit_cnt + 1'b1;
          if ((bit_cnt == 0) && rx_sync)
          begin
            // Glitch, line went back high before mid start bit
            busy <= 1'b0;
          end
          else if (bit_cnt == (hub_pkg::frame_bits - 1))
          begin
            busy        <= 1'b0;
            frame_valid <= rx_sync;
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== hw/serial_bus_tx.sv ====
`default_nettype none
`timescale 1ns/1ns

module serial_bus_tx (
  input  logic    clk,
  input  logic    rst,
  hub_wb_if.slave dl,
  output logic    tx
);

  logic                              ack;
  logic                              busy;
  logic                              accept;
  logic                              bit_end;
  logic [hub_pkg::frame_bits-1:0]    shreg;
  logic [hub_pkg::cyc_cnt_w-1:0]     cyc_cnt;
  logic [hub_pkg::bit_cnt_w-1:0]     bit_cnt;

  // Only an idle transmitter takes a new frame
  assign accept  = dl.cyc && dl.stb && !busy && !ack;
  assign bit_end = (cyc_cnt == (hub_pkg::bit_cycles - 1));
  assign dl.ack  = ack;

  // Stop bit, payload and start bit, shifted out from bit 0
  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      shreg <= {1'b1, dl.dat, 1'b0};
    end
    else if (ack || (busy && bit_end))
    begin
      shreg <= {1'b0, shreg[hub_pkg::frame_bits-1:1]};
    end
  end

  always_ff @(posedge clk)
  begin
    if (!rst)
    begin
      ack     <= 1'b0;
      busy    <= 1'b0;
      tx      <= 1'b1;
      cyc_cnt <= '0;
      bit_cnt <= '0;
    end
    else
    begin
      ack <= accept;
      if (ack)
      begin
        // Start bit goes out the cycle after the ack
        busy    <= 1'b1;
        tx      <= shreg[0];
        cyc_cnt <= '0;
        bit_cnt <= '0;
      end
      else if (busy)
      begin
        cyc_cnt <= bit_end ? '0 : cyc_cnt + 1'b1;
        if (bit_end)
        begin
          if (bit_cnt == (hub_pkg::frame_bits - 1))
          begin
            busy <= 1'b0;
            tx   <= 1'b1;
          end
          else
          begin
            bit_cnt <= bit_cnt + 1'b1;
            tx      <= shreg[0];
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== hw/uplink_arbiter.sv ====
`default_nettype none
`timescale 1ns/1ns

module uplink_arbiter (
  input  logic                clk,
  input  logic                rst,
  hub_wb_if.slave             req [hub_pkg::n_buses],
  output logic                up_cyc,
  output logic                up_stb,
  output hub_pkg::hub_frame_t up_dat,
  input  logic                up_ack
);

  logic [hub_pkg::n_buses-1:0] pending;
  logic [hub_pkg::n_buses-1:0] req_ack;
  hub_pkg::bus_payload_t       req_dat [hub_pkg::n_buses];
  logic [hub_pkg::chan_w-1:0]  ptr;
  logic [hub_pkg::chan_w-1:0]  grant;
  logic [hub_pkg::chan_w-1:0]  pick;
  logic                        found;
  logic                        locked;

  for (genvar g = 0; g < hub_pkg::n_buses; g++)
  begin : g_req
    assign pending[g] = req[g].cyc && req[g].stb;
    assign req_dat[g] = req[g].dat;
    assign req_ack[g] = locked && up_ack && (grant == g);
    assign req[g].ack = req_ack[g];
  end

  // First pending channel at or after the pointer
  always_comb
  begin
    int idx;
    found = 1'b0;
    pick  = ptr;
    for (int k = 0; k < hub_pkg::n_buses; k++)
    begin
      idx = (int'(ptr) + k) % hub_pkg::n_buses;
      if (!found && pending[idx])
      begin
        found = 1'b1;
        pick  = idx[hub_pkg::chan_w-1:0];
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (!rst)
    begin
      locked <= 1'b0;
      grant  <= '0;
      ptr    <= '0;
    end
    else if (!locked)
    begin
      if (found)
      begin
        locked <= 1'b1;
        grant  <= pick;
      end
    end
    else if (up_ack)
    begin
      locked <= 1'b0;
      ptr    <= (grant == (hub_pkg::n_buses - 1)) ? '0 : grant + 1'b1;
    end
  end

  assign up_cyc         = locked;
  assign up_stb         = locked;
  assign up_dat.bus_id  = {{(hub_pkg::bus_id_w - hub_pkg::chan_w){1'b0}}, grant};
  assign up_dat.payload = req_dat[grant];

endmodule

`default_nettype wire

// ==== tb/tb_hub_core.sv ====
`default_nettype none
`timescale 1ns/1ns

module tb_hub_core;

  localparam int clk_period = 8;
  localparam int frame_cycles = hub_pkg::frame_bits * hub_pkg::bit_cycles;
  localparam int frame_ns = frame_cycles * clk_period;
  localparam int n_tests = 6;

  logic                        clk;
  logic                        rst;
  logic                        down_cyc;
  logic                        down_stb;
  hub_pkg::hub_frame_t         down_dat;
  logic                        down_ack;
  logic                        up_cyc;
  logic                        up_stb;
  hub_pkg::hub_frame_t         up_dat;
  logic                        up_ack;
  logic [hub_pkg::n_buses-1:0] tx;
  logic [hub_pkg::n_buses-1:0] rx;

  // Expected and observed frames, tagged with their bus
  hub_pkg::hub_frame_t exp_tx [$];
  hub_pkg::hub_frame_t exp_up [$];
  hub_pkg::hub_frame_t tx_seen [$];
  hub_pkg::hub_frame_t up_seen [$];

  int errors = 0;
  int checks = 0;
  int tests_run = 0;
  int tests_failed = 0;
  int tx_starts = 0;
  int up_count = 0;

  hub_core i_hub_core (
    .clk      (clk),
    .rst      (rst),
    .down_cyc (down_cyc),
    .down_stb (down_stb),
    .down_dat (down_dat),
    .down_ack (down_ack),
    .up_cyc   (up_cyc),
    .up_stb   (up_stb),
    .up_dat   (up_dat),
    .up_ack   (up_ack),
    .tx       (tx),
    .rx       (rx)
  );

  initial
  begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  // Uplink frame as the hub should tag it
  function automatic hub_pkg::hub_frame_t expected_uplink(input int bus,
                                                          input hub_pkg::bus_payload_t p);
    hub_pkg::hub_frame_t f;
    f.bus_id  = bus[hub_pkg::bus_id_w-1:0];
    f.payload = p;
    return f;
  endfunction

  function automatic hub_pkg::bus_payload_t rand_payload();
    logic [95:0] r;
    r = {$urandom(), $urandom(), $urandom()};
    return hub_pkg::bus_payload_t'(r[hub_pkg::payload_w-1:0]);
  endfunction

  // Start bit, payload LSB first, stop bit
  task automatic send_rx(input int b, input hub_pkg::bus_payload_t p, input logic stop);
    logic [hub_pkg::frame_bits-1:0] bits;
    bits = {stop, p, 1'b0};
    for (int i = 0; i < hub_pkg::frame_bits; i++)
    begin
      @(posedge clk);
      #1;
      rx[b] = bits[i];
      repeat (hub_pkg::bit_cycles - 1) @(posedge clk);
    end
    @(posedge clk);
    #1;
    rx[b] = 1'b1;
  endtask

  // Decodes one tx line, sampling mid-bit on the falling clock edge
  task automatic watch_tx(input int b);
    logic [hub_pkg::payload_w-1:0] bits;
    hub_pkg::hub_frame_t           f;
    forever
    begin
      @(negedge clk);
      if (rst && tx[b] === 1'b0)
      begin
        tx_starts++;
        repeat (hub_pkg::bit_cycles / 2) @(negedge clk);
        if (tx[b] !== 1'b0)
        begin
          $display("[ERROR] %0t: start bit on tx %0d ended early", $time, b);
          errors++;
        end
        for (int i = 0; i < hub_pkg::payload_w; i++)
        begin
          repeat (hub_pkg::bit_cycles) @(negedge clk);
          bits[i] = tx[b];
        end
        repeat (hub_pkg::bit_cycles) @(negedge clk);
        if (tx[b] !== 1'b1)
        begin
          $display("[ERROR] %0t: stop bit on tx %0d is low", $time, b);
          errors++;
        end
        f.bus_id  = b[hub_pkg::bus_id_w-1:0];
        f.payload = hub_pkg::bus_payload_t'(bits);
        tx_seen.push_back(f);
      end
    end
  endtask

  initial
  begin
    for (int b = 0; b < hub_pkg::n_buses; b++)
    begin
      fork
        automatic int bb = b;
        watch_tx(bb);
      join_none
    end
  end

  // Uplink slave, acks after a random delay
  initial
  begin
    forever
    begin
      @(negedge clk);
      if (rst && up_cyc && up_stb)
      begin
        up_seen.push_back(up_dat);
        up_count++;
        repeat ($urandom_range(0, 5)) @(posedge clk);
        @(posedge clk);
        #1;
        up_ack = 1'b1;
        @(posedge clk);
        #1;
        up_ack = 1'b0;
      end
    end
  end

  // Tx frames must match in order per bus, uplink frames in any order
  initial
  begin
    hub_pkg::hub_frame_t got;
    int                  idx;
    forever
    begin
      @(negedge clk);
      while (tx_seen.size() != 0)
      begin
        got = tx_seen.pop_front();
        checks++;
        idx = -1;
        for (int i = 0; i < exp_tx.size(); i++)
        begin
          if (idx < 0 && exp_tx[i].bus_id == got.bus_id)
          begin
            idx = i;
          end
        end
        if (idx < 0)
        begin
          $display("[ERROR] %0t: unexpected frame on tx %0d", $time, got.bus_id);
          errors++;
        end
        else
        begin
          if (exp_tx[idx] !== got)
          begin
            $display("[ERROR] %0t: tx %0d payload %h, expected %h", $time, got.bus_id,
                     got.payload, exp_tx[idx].payload);
            errors++;
          end
          exp_tx.delete(idx);
        end
      end
      while (up_seen.size() != 0)
      begin
        got = up_seen.pop_front();
        checks++;
        idx = -1;
        for (int i = 0; i < exp_up.size(); i++)
        begin
          if (idx < 0 && exp_up[i] == got)
          begin
            idx = i;
          end
        end
        if (idx < 0)
        begin
          $display("[ERROR] %0t: unexpected uplink frame, bus %0d payload %h", $time,
                   got.bus_id, got.payload);
          errors++;
        end
        else
        begin
          exp_up.delete(idx);
        end
      end
    end
  end

  task automatic host_write(input hub_pkg::hub_frame_t f, output time t_ack);
    int n;
    @(posedge clk);
    #1;
    down_cyc = 1'b1;
    down_stb = 1'b1;
    down_dat = f;
    n = 0;
    do
    begin
      @(negedge clk);
      n++;
    end
    while (down_ack !== 1'b1 && n < 2 * frame_cycles);
    if (down_ack !== 1'b1)
    begin
      $display("Downlink frame for bus %0d was never acked", f.bus_id);
      errors++;
    end
    t_ack = $time;
    @(posedge clk);
    #1;
    down_cyc = 1'b0;
    down_stb = 1'b0;
  endtask

  task automatic wait_drained(input int limit);
    int n;
    n = 0;
    while ((exp_tx.size() != 0 || exp_up.size() != 0) && n < limit)
    begin
      @(negedge clk);
      n++;
    end
    if (exp_tx.size() != 0 || exp_up.size() != 0)
    begin
      $display("Missing frames: %0d on tx lines, %0d on the uplink", exp_tx.size(),
               exp_up.size());
      errors++;
      exp_tx.delete();
      exp_up.delete();
    end
  endtask

  task automatic end_test(input string name, input int errors_before);
    tests_run++;
    if (errors == errors_before)
    begin
      $display("Test %0d %s: pass", tests_run, name);
    end
    else
    begin
      tests_failed++;
      $display("Test %0d %s: FAIL", tests_run, name);
    end
  endtask

  // Watchdog
  initial
  begin
    #(n_tests * 20 * frame_ns);
    $display("Timeout: the tests did not finish in time");
    $display("Checks failed");
    $finish;
  end

  initial
  begin
    hub_pkg::bus_payload_t ps [hub_pkg::n_buses];
    hub_pkg::hub_frame_t   f;
    time                   t1;
    time                   t2;
    int                    b;
    int                    e0;
    int                    starts0;
    int                    up0;

    void'($urandom(93));
    rst = 1'b0;
    down_cyc = 1'b0;
    down_stb = 1'b0;
    down_dat = '0;
    up_ack = 1'b0;
    rx = '1;
    repeat (8) @(posedge clk);
    #1;
    rst = 1'b1;
    repeat (4) @(posedge clk);

    e0 = errors;
    starts0 = tx_starts;
    for (int i = 0; i < hub_pkg::n_buses; i++)
    begin
      f = expected_uplink(i, rand_payload());
      exp_tx.push_back(f);
      host_write(f, t1);
    end
    wait_drained(3 * frame_cycles);
    if (tx_starts - starts0 != hub_pkg::n_buses)
    begin
      $display("[ERROR] %0t: %0d tx frames seen, expected %0d", $time, tx_starts - starts0,
               hub_pkg::n_buses);
      errors++;
    end
    end_test("downlink to each bus", e0);

    e0 = errors;
    b = $urandom_range(0, hub_pkg::n_buses - 1);
    ps[0] = rand_payload();
    exp_up.push_back(expected_uplink(b, ps[0]));
    send_rx(b, ps[0], 1'b1);
    wait_drained(2 * frame_cycles);
    end_test("rx to uplink", e0);

    // Second ack must wait out the whole first frame
    e0 = errors;
    b = $urandom_range(0, hub_pkg::n_buses - 1);
    f = expected_uplink(b, rand_payload());
    exp_tx.push_back(f);
    host_write(f, t1);
    f = expected_uplink(b, rand_payload());
    exp_tx.push_back(f);
    host_write(f, t2);
    if (t2 - t1 <= frame_ns)
    begin
      $display("[ERROR] %0t: second ack after %0t ns, before tx %0d went idle", $time,
               t2 - t1, b);
      errors++;
    end
    wait_drained(3 * frame_cycles);
    end_test("back-to-back downlink", e0);

    e0 = errors;
    starts0 = tx_starts;
    f.bus_id = 5'($urandom_range(hub_pkg::n_buses, 31));
    f.payload = rand_payload();
    host_write(f, t1);
    repeat (3 * frame_cycles) @(negedge clk);
    if (tx_starts != starts0)
    begin
      $display("[ERROR] %0t: tx line active after frame to bus id %0d", $time, f.bus_id);
      errors++;
    end
    end_test("out-of-range bus id", e0);

    e0 = errors;
    for (int i = 0; i < hub_pkg::n_buses; i++)
    begin
      ps[i] = rand_payload();
      exp_up.push_back(expected_uplink(i, ps[i]));
    end
    for (int i = 0; i < hub_pkg::n_buses; i++)
    begin
      fork
        automatic int bb = i;
        send_rx(bb, ps[bb], 1'b1);
      join_none
    end
    wait fork;
    wait_drained(2 * frame_cycles);
    end_test("all rx lines at once", e0);

    e0 = errors;
    up0 = up_count;
    b = $urandom_range(0, hub_pkg::n_buses - 1);
    send_rx(b, rand_payload(), 1'b0);
    repeat (2 * frame_cycles) @(negedge clk);
    if (up_count != up0)
    begin
      $display("[ERROR] %0t: uplink transfer after bad stop bit on rx %0d", $time, b);
      errors++;
    end
    end_test("bad stop bit", e0);

    $display("Tests run %0d, failed %0d, frames checked %0d, errors %0d", tests_run,
             tests_failed, checks, errors);
    if (errors == 0)
    begin
      $display("All checks passed");
    end
    else
    begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
